// ==== src/dtm_pkg.sv ====
// jtag debug transport definitions
package dtm_pkg;

	// ********************
	// dmi word layout
	localparam int dmi_addr_bits = 7;
	localparam int dmi_data_bits = 32;
	localparam int dmi_op_bits = 2;
	localparam int dmi_word_bits = dmi_addr_bits + dmi_data_bits + dmi_op_bits;

	localparam int ir_bits = 5;

	localparam logic [31:0] jtag_idcode = 32'h1d5e_0c3b;

	// dtmcs fields
	localparam logic [2:0] dtmcs_idle = 3'd7;
	localparam logic [3:0] dtmcs_version = 4'd1;
	localparam logic [5:0] dtmcs_abits = 6'(dmi_addr_bits);

	// target response latency in tck cycles
	localparam int dmi_ack_delay = 6;
	localparam int ack_cnt_bits = $clog2(dmi_ack_delay + 1);

	// ********************
	// tap states, dr states have bit 3 set
	typedef enum logic [3:0] {
		st_test_logic_reset = 4'b0000,
		st_select_ir_scan   = 4'b0001,
		st_capture_ir       = 4'b0010,
		st_shift_ir         = 4'b0011,
		st_exit1_ir         = 4'b0100,
		st_pause_ir         = 4'b0101,
		st_exit2_ir         = 4'b0110,
		st_update_ir        = 4'b0111,
		st_run_test_idle    = 4'b1000,
		st_select_dr_scan   = 4'b1001,
		st_capture_dr       = 4'b1010,
		st_shift_dr         = 4'b1011,
		st_exit1_dr         = 4'b1100,
		st_pause_dr         = 4'b1101,
		st_exit2_dr         = 4'b1110,
		st_update_dr        = 4'b1111
	} tap_state_t;

	// instructions, anything else is bypass
	localparam logic [ir_bits-1:0] ir_idcode = 5'b00001;
	localparam logic [ir_bits-1:0] ir_dtmcs = 5'b10000;
	localparam logic [ir_bits-1:0] ir_dmi = 5'b10001;

	typedef enum logic [1:0] {
		dmi_nop       = 2'd0,
		dmi_read      = 2'd1,
		dmi_write     = 2'd2,
		dmi_busy_resp = 2'd3
	} dmi_op_t;

	typedef struct packed {
		logic [dmi_addr_bits-1:0] addr;
		logic [dmi_data_bits-1:0] data;
		dmi_op_t op;
	} dmi_word_t;

endpackage

// ==== src/dmi_if.sv ====
// dmi request channel
`timescale 1ns/1ps

interface dmi_if;

	logic req;
	logic [dtm_pkg::dmi_addr_bits-1:0] addr;
	logic [dtm_pkg::dmi_data_bits-1:0] wdata;
	dtm_pkg::dmi_op_t op;
	logic [dtm_pkg::dmi_data_bits-1:0] rdata;
	// single cycle pulse
	logic ack;

	modport initiator (output req, output addr, output wdata, output op,
		input rdata, input ack);

	modport target (input req, input addr, input wdata, input op,
		output rdata, output ack);

endinterface

// ==== src/tap_fsm.sv ====
// tap controller
`timescale 1ns/1ps

module tap_fsm (
	input  logic tck,
	input  logic pwr_rst_n,
	input  logic tms,
	output dtm_pkg::tap_state_t state,
	output logic in_reset,
	output logic capture_dr,
	output logic shift_dr,
	output logic update_dr,
	output logic capture_ir,
	output logic shift_ir,
	output logic update_ir
);

	dtm_pkg::tap_state_t state_nxt;

	always_comb begin
		case (state)
			dtm_pkg::st_test_logic_reset: state_nxt = tms ? dtm_pkg::st_test_logic_reset : dtm_pkg::st_run_test_idle;
			dtm_pkg::st_run_test_idle:    state_nxt = tms ? dtm_pkg::st_select_dr_scan : dtm_pkg::st_run_test_idle;
			dtm_pkg::st_select_dr_scan:   state_nxt = tms ? dtm_pkg::st_select_ir_scan : dtm_pkg::st_capture_dr;
			dtm_pkg::st_capture_dr:       state_nxt = tms ? dtm_pkg::st_exit1_dr : dtm_pkg::st_shift_dr;
			dtm_pkg::st_shift_dr:         state_nxt = tms ? dtm_pkg::st_exit1_dr : dtm_pkg::st_shift_dr;
			dtm_pkg::st_exit1_dr:         state_nxt = tms ? dtm_pkg::st_update_dr : dtm_pkg::st_pause_dr;
			dtm_pkg::st_pause_dr:         state_nxt = tms ? dtm_pkg::st_exit2_dr : dtm_pkg::st_pause_dr;
			dtm_pkg::st_exit2_dr:         state_nxt = tms ? dtm_pkg::st_update_dr : dtm_pkg::st_shift_dr;
			dtm_pkg::st_update_dr:        state_nxt = tms ? dtm_pkg::st_select_dr_scan : dtm_pkg::st_run_test_idle;
			dtm_pkg::st_select_ir_scan:   state_nxt = tms ? dtm_pkg::st_test_logic_reset : dtm_pkg::st_capture_ir;
			dtm_pkg::st_capture_ir:       state_nxt = tms ? dtm_pkg::st_exit1_ir : dtm_pkg::st_shift_ir;
			dtm_pkg::st_shift_ir:         state_nxt = tms ? dtm_pkg::st_exit1_ir : dtm_pkg::st_shift_ir;
			dtm_pkg::st_exit1_ir:         state_nxt = tms ? dtm_pkg::st_update_ir : dtm_pkg::st_pause_ir;
			dtm_pkg::st_pause_ir:         state_nxt = tms ? dtm_pkg::st_exit2_ir : dtm_pkg::st_pause_ir;
			dtm_pkg::st_exit2_ir:         state_nxt = tms ? dtm_pkg::st_update_ir : dtm_pkg::st_shift_ir;
			dtm_pkg::st_update_ir:        state_nxt = tms ? dtm_pkg::st_select_dr_scan : dtm_pkg::st_run_test_idle;
			// unknown encodings recover like the reset path
			default:                      state_nxt = tms ? dtm_pkg::st_test_logic_reset : dtm_pkg::st_run_test_idle;
		endcase
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			state <= dtm_pkg::st_test_logic_reset;
		end else begin
			state <= state_nxt;
		end
	end

	// ********************
	// state strobes
	assign in_reset = (state == dtm_pkg::st_test_logic_reset);
	assign capture_dr = (state == dtm_pkg::st_capture_dr);
	assign shift_dr = (state == dtm_pkg::st_shift_dr);
	assign update_dr = (state == dtm_pkg::st_update_dr);
	assign capture_ir = (state == dtm_pkg::st_capture_ir);
	assign shift_ir = (state == dtm_pkg::st_shift_ir);
	assign update_ir = (state == dtm_pkg::st_update_ir);

	// five tms-high edges reach reset from any state
	a_tms_reset: assert property (@(posedge tck) disable iff (!pwr_rst_n)
		tms [*5] |=> in_reset);

endmodule

// ==== src/tap_scan_regs.sv ====
// jtag scan registers
`timescale 1ns/1ps

module tap_scan_regs (
	input  logic tck,
	input  logic pwr_rst_n,
	input  logic tdi,
	output logic tdo,
	output logic tdo_out_en,
	input  logic in_reset,
	input  logic capture_dr,
	input  logic shift_dr,
	input  logic update_dr,
	input  logic capture_ir,
	input  logic shift_ir,
	input  logic update_ir,
	output logic update_dmi,
	output logic capture_dmi,
	output logic dtmcs_dmireset,
	output logic dtmcs_hardreset,
	output dtm_pkg::dmi_word_t shift_word,
	input  logic dmi_busy,
	input  logic pending,
	input  dtm_pkg::dmi_word_t resp_word
);

	logic [dtm_pkg::ir_bits-1:0] ir;
	logic [dtm_pkg::dmi_word_bits-1:0] sr;
	logic [dtm_pkg::dmi_word_bits-1:0] sr_nxt;
	logic [dtm_pkg::dmi_word_bits-1:0] cap_val;
	logic bypass_q;
	logic sel_idcode;
	logic sel_dtmcs;
	logic sel_dmi;
	logic sel_bypass;
	logic [1:0] dmistat;
	logic [31:0] dtmcs_val;
	dtm_pkg::dmi_word_t dmi_cap;

	assign sel_idcode = (ir == dtm_pkg::ir_idcode);
	assign sel_dtmcs = (ir == dtm_pkg::ir_dtmcs);
	assign sel_dmi = (ir == dtm_pkg::ir_dmi);
	assign sel_bypass = ~(sel_idcode | sel_dtmcs | sel_dmi);

	assign dmistat = dmi_busy ? 2'd3 : 2'd0;
	assign dtmcs_val = {14'd0, 2'b00, 1'b0, dtm_pkg::dtmcs_idle, dmistat,
		dtm_pkg::dtmcs_abits, dtm_pkg::dtmcs_version};

	// outstanding or blocked access reports busy in op
	always_comb begin
		dmi_cap = resp_word;
		if (dmi_busy || pending) begin
			dmi_cap.op = dtm_pkg::dmi_busy_resp;
		end
	end

	always_comb begin
		cap_val = '0;
		if (capture_ir) begin
			cap_val[dtm_pkg::ir_bits-1:0] = ir;
		end else if (sel_idcode) begin
			cap_val[31:0] = dtm_pkg::jtag_idcode;
		end else if (sel_dtmcs) begin
			cap_val[31:0] = dtmcs_val;
		end else if (sel_dmi) begin
			cap_val = dmi_cap;
		end
	end

	// ********************
	// capture and shift path
	always_comb begin
		sr_nxt = sr;
		if (capture_ir || capture_dr) begin
			sr_nxt = cap_val;
		end else if (shift_ir) begin
			sr_nxt = '0;
			sr_nxt[dtm_pkg::ir_bits-1:0] = {tdi, sr[dtm_pkg::ir_bits-1:1]};
		end else if (shift_dr && sel_dmi) begin
			sr_nxt = {tdi, sr[dtm_pkg::dmi_word_bits-1:1]};
		end else if (shift_dr && !sel_bypass) begin
			sr_nxt = '0;
			sr_nxt[31:0] = {tdi, sr[31:1]};
		end
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			sr <= '0;
		end else if (in_reset) begin
			sr <= '0;
		end else begin
			sr <= sr_nxt;
		end
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			ir <= dtm_pkg::ir_idcode;
		end else if (in_reset) begin
			ir <= dtm_pkg::ir_idcode;
		end else if (update_ir) begin
			ir <= sr[dtm_pkg::ir_bits-1:0];
		end
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			bypass_q <= 1'b0;
		end else if (capture_dr) begin
			bypass_q <= 1'b0;
		end else if (shift_dr) begin
			bypass_q <= tdi;
		end
	end

	// ********************
	// output on falling edge
	always_ff @(negedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			tdo <= 1'b0;
		end else if (shift_ir) begin
			tdo <= sr[0];
		end else if (shift_dr) begin
			tdo <= sel_bypass ? bypass_q : sr[0];
		end
	end

	always_ff @(negedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			tdo_out_en <= 1'b0;
		end else begin
			tdo_out_en <= shift_ir | shift_dr;
		end
	end

	assign update_dmi = update_dr & sel_dmi;
	assign capture_dmi = capture_dr & sel_dmi;
	assign dtmcs_dmireset = update_dr & sel_dtmcs & sr[16];
	assign dtmcs_hardreset = update_dr & sel_dtmcs & sr[17];
	assign shift_word = dtm_pkg::dmi_word_t'(sr);

	// enable set at the falling edge must match the state seen at the next rising edge
	a_oe_shift_only: assert property (@(posedge tck) disable iff (!pwr_rst_n)
		tdo_out_en |-> (shift_ir || shift_dr));

endmodule

// ==== src/dmi_tracker.sv ====
// dmi request tracker
`timescale 1ns/1ps

module dmi_tracker (
	input  logic tck,
	input  logic pwr_rst_n,
	input  logic update_dmi,
	input  logic capture_dmi,
	input  logic dtmcs_dmireset,
	input  logic dtmcs_hardreset,
	input  logic in_reset,
	input  dtm_pkg::dmi_word_t shift_word,
	output logic dmi_busy,
	output logic pending,
	output dtm_pkg::dmi_word_t resp_word,
	dmi_if.initiator dmi
);

	dtm_pkg::dmi_word_t req_word;
	logic start;
	logic is_access;
	logic busy_clr;

	assign is_access = (shift_word.op == dtm_pkg::dmi_read) ||
		(shift_word.op == dtm_pkg::dmi_write);
	assign start = update_dmi & ~dmi_busy;
	assign busy_clr = dtmcs_dmireset | dtmcs_hardreset | in_reset;
	assign pending = dmi.req;

	always_ff @(posedge tck) begin
		if (start) begin
			req_word <= shift_word;
		end
	end

	// level request, dropped on ack
	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			dmi.req <= 1'b0;
		end else if (dmi.ack || dtmcs_hardreset) begin
			dmi.req <= 1'b0;
		end else if (start && is_access) begin
			dmi.req <= 1'b1;
		end
	end

	// sticky until dmireset
	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			dmi_busy <= 1'b0;
		end else if (busy_clr) begin
			dmi_busy <= 1'b0;
		end else if (capture_dmi && dmi.req) begin
			dmi_busy <= 1'b1;
		end
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			resp_word <= '0;
		end else if (dmi.ack) begin
			resp_word.addr <= req_word.addr;
			resp_word.data <= dmi.rdata;
			resp_word.op <= dtm_pkg::dmi_nop;
		end
	end

	assign dmi.addr = req_word.addr;
	assign dmi.wdata = req_word.data;
	assign dmi.op = req_word.op;

	a_no_req_busy: assert property (@(posedge tck) disable iff (!pwr_rst_n)
		$rose(dmi.req) |-> $past(!dmi_busy));

endmodule

// ==== src/dmi_reg_target.sv ====
// dmi register file target
`timescale 1ns/1ps

module dmi_reg_target (
	input logic tck,
	input logic pwr_rst_n,
	dmi_if.target dmi
);

	logic [dtm_pkg::ack_cnt_bits-1:0] cnt;
	logic [dtm_pkg::dmi_data_bits-1:0] mem [4];
	logic hit;

	assign hit = dmi.req && !dmi.ack &&
		(cnt == dtm_pkg::ack_cnt_bits'(dtm_pkg::dmi_ack_delay));

	// counts from the first cycle req is seen
	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			cnt <= '0;
			dmi.ack <= 1'b0;
		end else begin
			dmi.ack <= hit;
			if (dmi.req && !dmi.ack && !hit) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= '0;
			end
		end
	end

	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			for (int i = 0; i < 4; i++) begin
				mem[i] <= '0;
			end
		end else if (hit && dmi.op == dtm_pkg::dmi_write) begin
			mem[dmi.addr[1:0]] <= dmi.wdata;
		end
	end

	// write echoes new data
	always_ff @(posedge tck) begin
		if (hit) begin
			dmi.rdata <= (dmi.op == dtm_pkg::dmi_write) ? dmi.wdata : mem[dmi.addr[1:0]];
		end
	end

endmodule

// ==== src/jtag_dtm_top.sv ====
// jtag debug transport top
`timescale 1ns/1ps

module jtag_dtm_top (
	input  logic tck,
	input  logic pwr_rst_n,
	input  logic tms,
	input  logic tdi,
	output logic tdo,
	output logic tdo_out_en,
	output logic dbg_wakeup_req
);

	dtm_pkg::tap_state_t tap_state;
	logic in_reset, capture_dr, shift_dr, update_dr;
	logic capture_ir, shift_ir, update_ir;
	logic update_dmi, capture_dmi, dtmcs_dmireset, dtmcs_hardreset;
	logic dmi_busy, pending;
	dtm_pkg::dmi_word_t shift_word;
	dtm_pkg::dmi_word_t resp_word;

	dmi_if dmi_bus ();

	tap_fsm tap_fsm_inst (.tck(tck), .pwr_rst_n(pwr_rst_n), .tms(tms), .state(tap_state),
		.in_reset(in_reset), .capture_dr(capture_dr), .shift_dr(shift_dr),
		.update_dr(update_dr), .capture_ir(capture_ir), .shift_ir(shift_ir),
		.update_ir(update_ir));

	tap_scan_regs tap_scan_regs_inst (.tck(tck), .pwr_rst_n(pwr_rst_n), .tdi(tdi),
		.tdo(tdo), .tdo_out_en(tdo_out_en), .in_reset(in_reset),
		.capture_dr(capture_dr), .shift_dr(shift_dr), .update_dr(update_dr),
		.capture_ir(capture_ir), .shift_ir(shift_ir), .update_ir(update_ir),
		.update_dmi(update_dmi), .capture_dmi(capture_dmi),
		.dtmcs_dmireset(dtmcs_dmireset), .dtmcs_hardreset(dtmcs_hardreset),
		.shift_word(shift_word), .dmi_busy(dmi_busy), .pending(pending),
		.resp_word(resp_word));

	dmi_tracker dmi_tracker_inst (.tck(tck), .pwr_rst_n(pwr_rst_n),
		.update_dmi(update_dmi), .capture_dmi(capture_dmi),
		.dtmcs_dmireset(dtmcs_dmireset), .dtmcs_hardreset(dtmcs_hardreset),
		.in_reset(in_reset), .shift_word(shift_word), .dmi_busy(dmi_busy),
		.pending(pending), .resp_word(resp_word), .dmi(dmi_bus.initiator));

	dmi_reg_target dmi_reg_target_inst (.tck(tck), .pwr_rst_n(pwr_rst_n),
		.dmi(dmi_bus.target));

	// wakeup latches once tap leaves reset
	always_ff @(posedge tck or negedge pwr_rst_n) begin
		if (!pwr_rst_n) begin
			dbg_wakeup_req <= 1'b0;
		end else begin
			dbg_wakeup_req <= dbg_wakeup_req | (tap_state != dtm_pkg::st_test_logic_reset);
		end
	end

endmodule

// ==== tb/tb_jtag_dtm.sv ====
// jtag dtm testbench
`timescale 1ns/1ps

module tb_jtag_dtm;

	localparam int clk_period = 4;
	// roughly 1400 cycles of scans and idle gaps, with margin
	localparam int watchdog_cycles = 4000;

	logic tck;
	logic pwr_rst_n;
	logic tms;
	logic tdi;
	logic tdo;
	logic tdo_out_en;
	logic dbg_wakeup_req;

	int errors;
	logic [31:0] lfsr;
	logic [31:0] ref_mem [4];

	jtag_dtm_top jtag_dtm_top_inst (.tck(tck), .pwr_rst_n(pwr_rst_n), .tms(tms), .tdi(tdi),
		.tdo(tdo), .tdo_out_en(tdo_out_en), .dbg_wakeup_req(dbg_wakeup_req));

	initial begin
		tck = 1'b0;
		forever #(clk_period / 2) tck = ~tck;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: tests still running after %0d tck cycles", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	// ********************
	// reference model and helpers
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// only addr bits 1:0 select a word
	function automatic logic [31:0] ref_dmi(input logic [1:0] op, input logic [6:0] addr,
		input logic [31:0] data);
		if (op == 2'd2) begin
			ref_mem[addr[1:0]] = data;
		end
		return ref_mem[addr[1:0]];
	endfunction

	// version 1, abits 7, idle 7
	function automatic logic [40:0] expected_dtmcs(input logic [1:0] stat);
		return {9'd0, 17'd0, 3'd7, stat, 6'd7, 4'd1};
	endfunction

	task automatic check(input logic [40:0] got, input logic [40:0] exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	// tdo is updated on the falling edge, so it is steady at the rising edge
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(negedge tck);
		tms = tms_v;
		tdi = tdi_v;
		@(posedge tck);
		tdo_v = tdo;
	endtask

	// tms bits applied lsb first
	task automatic move_tap(input logic [7:0] seq, input int n);
		logic unused;
		for (int i = 0; i < n; i++) begin
			tck_cycle(seq[i], 1'b0, unused);
		end
	endtask

	task automatic run_idle(input int n);
		logic unused;
		for (int i = 0; i < n; i++) begin
			tck_cycle(1'b0, 1'b0, unused);
			check(41'(tdo_out_en), 41'd0, "tdo enable low in idle");
		end
	endtask

	task automatic scan_ir(input logic [4:0] ir_in, output logic [4:0] ir_out);
		logic b;
		move_tap(8'b0000_0011, 4);
		for (int i = 0; i < 5; i++) begin
			tck_cycle(i == 4, ir_in[i], b);
			ir_out[i] = b;
			check(41'(tdo_out_en), 41'd1, "tdo enable in ir shift");
		end
		move_tap(8'b0000_0001, 2);
	endtask

	// idle to idle, n bits through shift_dr
	task automatic scan_dr(input logic [40:0] din, input int n, output logic [40:0] dout);
		logic b;
		dout = '0;
		move_tap(8'b0000_0001, 3);
		for (int i = 0; i < n; i++) begin
			tck_cycle(i == n - 1, din[i], b);
			dout[i] = b;
			check(41'(tdo_out_en), 41'd1, "tdo enable in dr shift");
		end
		move_tap(8'b0000_0001, 2);
	endtask

	task automatic dmi_read_check(input logic [6:0] addr, input string msg);
		logic [40:0] dout;
		scan_dr({addr, 32'd0, 2'd1}, 41, dout);
		run_idle(12);
		scan_dr(41'd0, 41, dout);
		check(dout, {addr, ref_dmi(2'd1, addr, 32'd0), 2'd0}, msg);
	endtask

	// ********************
	// test sequence
	initial begin
		logic [40:0] dout;
		logic [4:0] ir_out;
		logic [6:0] addr;
		logic [31:0] data;
		errors = 0;
		lfsr = 32'hacf0;
		pwr_rst_n = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		for (int i = 0; i < 4; i++) begin
			ref_mem[i] = '0;
		end
		repeat (8) @(negedge tck);
		pwr_rst_n = 1'b1;
		check(41'(dbg_wakeup_req), 41'd0, "wakeup low while tap in reset");
		check(41'(tdo_out_en), 41'd0, "tdo enable low after reset");

		move_tap(8'b0000_0001, 2);
		scan_dr(41'd0, 32, dout);
		check(dout, 41'(dtm_pkg::jtag_idcode), "idcode after reset");
		check(41'(dbg_wakeup_req), 41'd1, "wakeup after leaving reset");

		scan_ir(dtm_pkg::ir_dtmcs, ir_out);
		check(41'(ir_out), 41'(5'b00001), "ir capture shows previous ir");
		scan_dr(41'd0, 32, dout);
		check(dout, expected_dtmcs(2'd0), "dtmcs fields");

		// writes with enough idle for the target delay
		scan_ir(dtm_pkg::ir_dmi, ir_out);
		for (int k = 0; k < 6; k++) begin
			addr = 7'(rand_bits(7));
			data = rand_bits(32);
			scan_dr({addr, data, 2'd2}, 41, dout);
			void'(ref_dmi(2'd2, addr, data));
			run_idle(12);
		end
		for (int k = 0; k < 4; k++) begin
			dmi_read_check(7'(k), "dmi read back");
		end

		// back to back scans hit a pending request
		addr = 7'(rand_bits(7));
		data = rand_bits(32);
		scan_dr({addr, data, 2'd2}, 41, dout);
		void'(ref_dmi(2'd2, addr, data));
		scan_dr(41'd0, 41, dout);
		check(41'(dout[1:0]), 41'd3, "busy op on back to back scan");
		scan_ir(dtm_pkg::ir_dtmcs, ir_out);
		scan_dr(41'd0, 32, dout);
		check(dout, expected_dtmcs(2'd3), "dtmcs dmistat while busy");
		scan_ir(dtm_pkg::ir_dmi, ir_out);
		scan_dr({addr, ~data, 2'd2}, 41, dout);
		check(41'(dout[1:0]), 41'd3, "busy op while sticky");
		run_idle(12);
		scan_ir(dtm_pkg::ir_dtmcs, ir_out);
		scan_dr(41'(32'h0001_0000), 32, dout);
		scan_ir(dtm_pkg::ir_dmi, ir_out);
		dmi_read_check(addr, "read after dmireset");

		scan_ir(5'b00101, ir_out);
		check(41'(ir_out), 41'(dtm_pkg::ir_dmi), "ir capture before bypass");
		data = rand_bits(16);
		scan_dr(41'(data), 16, dout);
		check(dout, 41'({data[14:0], 1'b0}), "bypass one bit delay");

		// five tms high edges, then back to idle
		move_tap(8'b0001_1111, 6);
		scan_dr(41'd0, 32, dout);
		check(dout, 41'(dtm_pkg::jtag_idcode), "idcode after tms reset");

		$display("tests done, error count: %0d", errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
src/dtm_pkg.sv
src/dmi_if.sv
src/tap_fsm.sv
src/tap_scan_regs.sv
src/dmi_tracker.sv
src/dmi_reg_target.sv
src/jtag_dtm_top.sv
tb/tb_jtag_dtm.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the jtag dtm testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_jtag_dtm -f filelist.f \
	--Mdir obj_dir -o tb_jtag_dtm_sim \
	&& ./obj_dir/tb_jtag_dtm_sim | tee /dev/stderr | grep -qx "sim passed" \
	&& echo "run ok" \
	|| { echo "run failed"; exit 1; }
